// ==== soc_bus_pkg.sv ====
package soc_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // sram window is 0x8000_0000 .. 0x87ff_ffff.
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] SRAM_MASK = 32'hf800_0000;
  localparam int SRAM_AW = 8; // 256 words, aliases every 1 KiB.

  localparam logic [ADDR_W-1:0] CLINT_MTIME_LO = 32'ha000_0048;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_HI = 32'ha000_004c;

  localparam logic [ADDR_W-1:0] UART_TX_ADDR = 32'ha000_03f8;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } axi_resp_e;

  typedef enum logic [1:0] {
    SEL_SRAM,
    SEL_CLINT,
    SEL_UART,
    SEL_ERR // no legal target.
  } slave_sel_e;

  typedef enum logic {
    IDLE,
    BUSY
  } chan_state_e;

endpackage

// ==== axi_xbar.sv ====
`timescale 1ns/1ps

module axi_xbar import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  // manager side.
  input  logic [ADDR_W-1:0] s_ar_addr,
  input  logic              s_ar_valid,
  output logic              s_ar_ready,
  output logic [DATA_W-1:0] s_r_data,
  output logic [1:0]        s_r_resp,
  output logic              s_r_valid,
  input  logic              s_r_ready,
  input  logic [ADDR_W-1:0] s_aw_addr,
  input  logic              s_aw_valid,
  output logic              s_aw_ready,
  input  logic [DATA_W-1:0] s_w_data,
  input  logic [STRB_W-1:0] s_w_strb,
  input  logic              s_w_valid,
  output logic              s_w_ready,
  output logic [1:0]        s_b_resp,
  output logic              s_b_valid,
  input  logic              s_b_ready,
  // sram link.
  output logic [ADDR_W-1:0] sram_ar_addr,
  output logic              sram_ar_valid,
  input  logic              sram_ar_ready,
  input  logic [DATA_W-1:0] sram_r_data,
  input  logic [1:0]        sram_r_resp,
  input  logic              sram_r_valid,
  output logic              sram_r_ready,
  output logic [ADDR_W-1:0] sram_aw_addr,
  output logic              sram_aw_valid,
  input  logic              sram_aw_ready,
  output logic [DATA_W-1:0] sram_w_data,
  output logic [STRB_W-1:0] sram_w_strb,
  output logic              sram_w_valid,
  input  logic              sram_w_ready,
  input  logic [1:0]        sram_b_resp,
  input  logic              sram_b_valid,
  output logic              sram_b_ready,
  // read-only clint link.
  output logic [ADDR_W-1:0] clint_ar_addr,
  output logic              clint_ar_valid,
  input  logic              clint_ar_ready,
  input  logic [DATA_W-1:0] clint_r_data,
  input  logic [1:0]        clint_r_resp,
  input  logic              clint_r_valid,
  output logic              clint_r_ready,
  // write-only uart link.
  output logic [ADDR_W-1:0] uart_aw_addr,
  output logic              uart_aw_valid,
  input  logic              uart_aw_ready,
  output logic [DATA_W-1:0] uart_w_data,
  output logic [STRB_W-1:0] uart_w_strb,
  output logic              uart_w_valid,
  input  logic              uart_w_ready,
  input  logic [1:0]        uart_b_resp,
  input  logic              uart_b_valid,
  output logic              uart_b_ready
);

  chan_state_e rd_state;
  chan_state_e wr_state;
  slave_sel_e  rd_sel_d;
  slave_sel_e  rd_sel_q;
  slave_sel_e  wr_sel_d;
  slave_sel_e  wr_sel_q;
  logic        wr_req;
  logic        wr_accept;

  // reads of the write-only uart register decode as errors.
  always_comb begin
    if ((s_ar_addr & SRAM_MASK) == SRAM_BASE) rd_sel_d = SEL_SRAM;
    else if (s_ar_addr[ADDR_W-1:3] == CLINT_MTIME_LO[ADDR_W-1:3]) rd_sel_d = SEL_CLINT;
    else rd_sel_d = SEL_ERR;
  end

  always_comb begin
    if ((s_aw_addr & SRAM_MASK) == SRAM_BASE) wr_sel_d = SEL_SRAM;
    else if (s_aw_addr[ADDR_W-1:2] == UART_TX_ADDR[ADDR_W-1:2]) wr_sel_d = SEL_UART;
    else wr_sel_d = SEL_ERR; // clint writes land here too.
  end

  assign sram_ar_addr   = s_ar_addr;
  assign clint_ar_addr  = s_ar_addr;
  assign sram_ar_valid  = (rd_state == IDLE) && s_ar_valid && (rd_sel_d == SEL_SRAM);
  assign clint_ar_valid = (rd_state == IDLE) && s_ar_valid && (rd_sel_d == SEL_CLINT);

  always_comb begin
    case (rd_sel_d)
      SEL_SRAM:  s_ar_ready = (rd_state == IDLE) && sram_ar_ready;
      SEL_CLINT: s_ar_ready = (rd_state == IDLE) && clint_ar_ready;
      default:   s_ar_ready = (rd_state == IDLE); // error answered locally.
    endcase
  end

  // response follows the latched target.
  always_comb begin
    case (rd_sel_q)
      SEL_SRAM: begin
        s_r_data  = sram_r_data;
        s_r_resp  = sram_r_resp;
        s_r_valid = sram_r_valid;
      end
      SEL_CLINT: begin
        s_r_data  = clint_r_data;
        s_r_resp  = clint_r_resp;
        s_r_valid = clint_r_valid;
      end
      default: begin
        s_r_data  = '0;
        s_r_resp  = DECERR;
        s_r_valid = (rd_state == BUSY);
      end
    endcase
  end

  assign sram_r_ready  = (rd_sel_q == SEL_SRAM) && s_r_ready;
  assign clint_r_ready = (rd_sel_q == SEL_CLINT) && s_r_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_state <= IDLE;
      rd_sel_q <= SEL_ERR;
    end else if (s_ar_valid && s_ar_ready) begin
      rd_state <= BUSY;
      rd_sel_q <= rd_sel_d;
    end else if (s_r_valid && s_r_ready) begin
      rd_state <= IDLE;
    end
  end

  assign wr_req        = (wr_state == IDLE) && s_aw_valid && s_w_valid;
  assign sram_aw_addr  = s_aw_addr;
  assign sram_w_data   = s_w_data;
  assign sram_w_strb   = s_w_strb;
  assign uart_aw_addr  = s_aw_addr;
  assign uart_w_data   = s_w_data;
  assign uart_w_strb   = s_w_strb;
  assign sram_aw_valid = wr_req && (wr_sel_d == SEL_SRAM);
  assign sram_w_valid  = wr_req && (wr_sel_d == SEL_SRAM);
  assign uart_aw_valid = wr_req && (wr_sel_d == SEL_UART);
  assign uart_w_valid  = wr_req && (wr_sel_d == SEL_UART);

  always_comb begin
    case (wr_sel_d)
      SEL_SRAM: wr_accept = sram_aw_ready && sram_w_ready;
      SEL_UART: wr_accept = uart_aw_ready && uart_w_ready;
      default:  wr_accept = 1'b1;
    endcase
  end

  assign s_aw_ready = wr_req && wr_accept;
  assign s_w_ready  = s_aw_ready;

  always_comb begin
    case (wr_sel_q)
      SEL_SRAM: begin
        s_b_resp  = sram_b_resp;
        s_b_valid = sram_b_valid;
      end
      SEL_UART: begin
        s_b_resp  = uart_b_resp;
        s_b_valid = uart_b_valid;
      end
      default: begin
        s_b_resp  = DECERR;
        s_b_valid = (wr_state == BUSY);
      end
    endcase
  end

  assign sram_b_ready = (wr_sel_q == SEL_SRAM) && s_b_ready;
  assign uart_b_ready = (wr_sel_q == SEL_UART) && s_b_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_state <= IDLE;
      wr_sel_q <= SEL_ERR;
    end else if (s_aw_valid && s_aw_ready) begin
      wr_state <= BUSY;
      wr_sel_q <= wr_sel_d;
    end else if (s_b_valid && s_b_ready) begin
      wr_state <= IDLE;
    end
  end

  a_r_valid_busy: assert property (@(posedge clk) disable iff (rstn)
    s_r_valid |-> rd_state == BUSY)
    else $error("r_valid with read tracker idle, sel %s", rd_sel_q.name());

  a_b_valid_busy: assert property (@(posedge clk) disable iff (rstn)
    s_b_valid |-> wr_state == BUSY)
    else $error("b_valid with write tracker idle, sel %s", wr_sel_q.name());

  // only one read may be in flight across the subordinates.
  a_rd_onehot: assert property (@(posedge clk) disable iff (rstn)
    $onehot0({sram_r_valid, clint_r_valid}))
    else $error("more than one subordinate read response pending");

endmodule

// ==== axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [ADDR_W-1:0] ar_addr,
  input  logic              ar_valid,
  output logic              ar_ready,
  output logic [DATA_W-1:0] r_data,
  output logic [1:0]        r_resp,
  output logic              r_valid,
  input  logic              r_ready,
  input  logic [ADDR_W-1:0] aw_addr,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  logic [DATA_W-1:0] w_data,
  input  logic [STRB_W-1:0] w_strb,
  input  logic              w_valid,
  output logic              w_ready,
  output logic [1:0]        b_resp,
  output logic              b_valid,
  input  logic              b_ready
);

  logic [DATA_W-1:0]  mem [2**SRAM_AW];
  logic [SRAM_AW-1:0] rd_idx;
  logic [SRAM_AW-1:0] wr_idx;
  logic               wr_go;

  assign rd_idx   = ar_addr[SRAM_AW+1:2];
  assign wr_idx   = aw_addr[SRAM_AW+1:2];
  assign ar_ready = !r_valid;
  assign wr_go    = aw_valid && w_valid && !b_valid; // address and data taken together.
  assign aw_ready = wr_go;
  assign w_ready  = wr_go;
  assign r_resp   = OKAY;
  assign b_resp   = OKAY;

  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) r_data <= mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (w_strb[i]) mem[wr_idx][8*i +: 8] <= w_data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) r_valid <= 1'b1;
      else if (r_ready) r_valid <= 1'b0;
      if (wr_go) b_valid <= 1'b1;
      else if (b_ready) b_valid <= 1'b0;
    end
  end

endmodule

// ==== axi_clint.sv ====
`timescale 1ns/1ps

module axi_clint import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [ADDR_W-1:0] ar_addr,
  input  logic              ar_valid,
  output logic              ar_ready,
  output logic [DATA_W-1:0] r_data,
  output logic [1:0]        r_resp,
  output logic              r_valid,
  input  logic              r_ready
);

  logic [63:0]       mtime;
  logic [DATA_W-1:0] snap_hi; // upper half captured with the low word.

  assign ar_ready = !r_valid;
  assign r_resp   = OKAY;

  always_ff @(posedge clk) begin
    if (rstn) mtime <= '0;
    else mtime <= mtime + 64'd1;
  end

  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      if (ar_addr == CLINT_MTIME_LO) begin
        r_data  <= mtime[31:0];
        snap_hi <= mtime[63:32];
      end else if (ar_addr == CLINT_MTIME_HI) begin
        r_data <= snap_hi;
      end else begin
        r_data <= '0; // unaligned offsets in the window.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) r_valid <= 1'b0;
    else if (ar_valid && ar_ready) r_valid <= 1'b1;
    else if (r_ready) r_valid <= 1'b0;
  end

endmodule

// ==== axi_uart_tx.sv ====
`timescale 1ns/1ps

module axi_uart_tx import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [ADDR_W-1:0] aw_addr,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  logic [DATA_W-1:0] w_data,
  input  logic [STRB_W-1:0] w_strb,
  input  logic              w_valid,
  output logic              w_ready,
  output logic [1:0]        b_resp,
  output logic              b_valid,
  input  logic              b_ready,
  output logic              tx_valid,
  output logic [7:0]        tx_data,
  input  logic              tx_ready
);

  logic wr_go;
  logic byte_ok;

  // holding register must be empty before the next write.
  assign wr_go    = aw_valid && w_valid && !b_valid && !tx_valid;
  assign aw_ready = wr_go;
  assign w_ready  = wr_go;
  assign byte_ok  = w_strb[0] && (aw_addr[ADDR_W-1:2] == UART_TX_ADDR[ADDR_W-1:2]);

  always_ff @(posedge clk) begin
    if (wr_go) begin
      b_resp <= byte_ok ? OKAY : SLVERR;
      if (byte_ok) tx_data <= w_data[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      b_valid  <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      if (wr_go) b_valid <= 1'b1;
      else if (b_ready) b_valid <= 1'b0;
      if (wr_go && byte_ok) tx_valid <= 1'b1;
      else if (tx_ready) tx_valid <= 1'b0;
    end
  end

  a_tx_hold: assert property (@(posedge clk) disable iff (rstn)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else $error("tx byte dropped or changed under back-pressure");

endmodule

// ==== soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [ADDR_W-1:0] s_ar_addr,
  input  logic              s_ar_valid,
  output logic              s_ar_ready,
  output logic [DATA_W-1:0] s_r_data,
  output logic [1:0]        s_r_resp,
  output logic              s_r_valid,
  input  logic              s_r_ready,
  input  logic [ADDR_W-1:0] s_aw_addr,
  input  logic              s_aw_valid,
  output logic              s_aw_ready,
  input  logic [DATA_W-1:0] s_w_data,
  input  logic [STRB_W-1:0] s_w_strb,
  input  logic              s_w_valid,
  output logic              s_w_ready,
  output logic [1:0]        s_b_resp,
  output logic              s_b_valid,
  input  logic              s_b_ready,
  output logic              tx_valid,
  output logic [7:0]        tx_data,
  input  logic              tx_ready
);

  logic [ADDR_W-1:0] sram_ar_addr;
  logic [ADDR_W-1:0] sram_aw_addr;
  logic [DATA_W-1:0] sram_r_data;
  logic [DATA_W-1:0] sram_w_data;
  logic [STRB_W-1:0] sram_w_strb;
  logic [1:0]        sram_r_resp;
  logic [1:0]        sram_b_resp;
  logic              sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
  logic              sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
  logic              sram_b_valid, sram_b_ready;

  logic [ADDR_W-1:0] clint_ar_addr;
  logic [DATA_W-1:0] clint_r_data;
  logic [1:0]        clint_r_resp;
  logic              clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;

  logic [ADDR_W-1:0] uart_aw_addr;
  logic [DATA_W-1:0] uart_w_data;
  logic [STRB_W-1:0] uart_w_strb;
  logic [1:0]        uart_b_resp;
  logic              uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
  logic              uart_b_valid, uart_b_ready;

  // crossbar port names match the link wires.
  axi_xbar i_axi_xbar (.*);

  axi_sram i_axi_sram (
    .clk, .rstn,
    .ar_addr(sram_ar_addr), .ar_valid(sram_ar_valid), .ar_ready(sram_ar_ready),
    .r_data (sram_r_data),  .r_resp  (sram_r_resp),   .r_valid (sram_r_valid),
    .r_ready(sram_r_ready),
    .aw_addr(sram_aw_addr), .aw_valid(sram_aw_valid), .aw_ready(sram_aw_ready),
    .w_data (sram_w_data),  .w_strb  (sram_w_strb),   .w_valid (sram_w_valid),
    .w_ready(sram_w_ready),
    .b_resp (sram_b_resp),  .b_valid (sram_b_valid),  .b_ready (sram_b_ready)
  );

  axi_clint i_axi_clint (
    .clk, .rstn,
    .ar_addr(clint_ar_addr), .ar_valid(clint_ar_valid), .ar_ready(clint_ar_ready),
    .r_data (clint_r_data),  .r_resp  (clint_r_resp),   .r_valid (clint_r_valid),
    .r_ready(clint_r_ready)
  );

  axi_uart_tx i_axi_uart_tx (
    .clk, .rstn,
    .aw_addr(uart_aw_addr), .aw_valid(uart_aw_valid), .aw_ready(uart_aw_ready),
    .w_data (uart_w_data),  .w_strb  (uart_w_strb),   .w_valid (uart_w_valid),
    .w_ready(uart_w_ready),
    .b_resp (uart_b_resp),  .b_valid (uart_b_valid),  .b_ready (uart_b_ready),
    .tx_valid, .tx_data, .tx_ready
  );

endmodule

// ==== tb_soc_bus.sv ====
`timescale 1ns/1ps

module tb_soc_bus import soc_bus_pkg::*; ();

  localparam int          N_TESTS = 17;
  localparam logic [31:0] SEED    = 32'hc517;

  typedef enum logic {OP_RD, OP_WR} op_e;

  typedef struct {
    string       name;
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data; // write data, or expected word for non-sram reads.
    logic [3:0]  strb;
    logic [1:0]  resp;
    int          hold; // cycles the response ready stays low.
  } entry_t;

  logic        clk, rstn;
  logic [31:0] s_ar_addr, s_aw_addr, s_w_data, s_r_data;
  logic [3:0]  s_w_strb;
  logic [1:0]  s_r_resp, s_b_resp;
  logic        s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
  logic        s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
  logic        tx_valid, tx_ready;
  logic [7:0]  tx_data;

  entry_t      tbl [N_TESTS];
  int          n_tbl;
  logic [31:0] shadow [256];
  logic [7:0]  exp_q [$];
  logic [7:0]  rx_q [$];
  logic [31:0] data_st, stall_st, last_lo;

  soc_bus_top i_soc_bus_top (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "compare failed");
    end
  endtask

  task automatic add_entry(input string name, input op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [1:0] resp, input int hold);
    tbl[n_tbl] = '{name, op, addr, data, strb, resp, hold};
    n_tbl++;
  endtask

  task automatic do_read(input entry_t e, output logic [31:0] data, output logic [1:0] resp);
    @(posedge clk);
    #2;
    s_ar_addr  = e.addr;
    s_ar_valid = 1'b1;
    s_r_ready  = (e.hold == 0);
    do @(negedge clk); while (!s_ar_ready);
    @(posedge clk);
    #2 s_ar_valid = 1'b0;
    do @(negedge clk); while (!s_r_valid);
    data = s_r_data;
    resp = s_r_resp;
    repeat (e.hold) begin
      @(negedge clk);
      check_eq({e.name, " held"}, 64'({1'b1, 1'b0, resp, data}),
               64'({s_r_valid, s_ar_ready, s_r_resp, s_r_data}));
    end
    if (e.hold > 0) begin
      @(posedge clk);
      #2 s_r_ready = 1'b1;
    end
    @(posedge clk); // r transfer.
  endtask

  task automatic do_write(input entry_t e, input logic [31:0] wdata, output logic [1:0] resp);
    @(posedge clk);
    #2;
    s_aw_addr  = e.addr;
    s_aw_valid = 1'b1;
    s_w_data   = wdata;
    s_w_strb   = e.strb;
    s_w_valid  = 1'b1;
    s_b_ready  = (e.hold == 0);
    do @(negedge clk); while (!s_aw_ready);
    check_eq({e.name, " w_ready"}, 64'd1, 64'(s_w_ready));
    @(posedge clk);
    #2;
    s_aw_valid = 1'b0;
    s_w_valid  = 1'b0;
    do @(negedge clk); while (!s_b_valid);
    resp = s_b_resp;
    repeat (e.hold) begin
      @(negedge clk);
      check_eq({e.name, " held"}, 64'({1'b1, resp}), 64'({s_b_valid, s_b_resp}));
    end
    if (e.hold > 0) begin
      @(posedge clk);
      #2 s_b_ready = 1'b1;
    end
    @(posedge clk); // b transfer.
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (N_TESTS * 64) @(posedge clk);
    $display("timeout: run exceeded %0d cycles", N_TESTS * 64);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  // byte sink with random back-pressure.
  initial begin
    tx_ready = 1'b0;
    stall_st = SEED;
    forever begin
      @(negedge clk);
      if (tx_valid && tx_ready) rx_q.push_back(tx_data);
      @(posedge clk);
      stall_st = xorshift(stall_st);
      #2 tx_ready = stall_st[0];
    end
  end

  initial begin
    entry_t      e;
    logic [31:0] data;
    logic [31:0] exp;
    logic [1:0]  resp;
    {s_ar_addr, s_ar_valid, s_r_ready, s_aw_addr, s_aw_valid} = '0;
    {s_w_data, s_w_strb, s_w_valid, s_b_ready} = '0;
    rstn    = 1'b1;
    data_st = SEED;
    last_lo = '0;
    n_tbl   = 0;
    add_entry("sram wr word 0x010", OP_WR, 32'h8000_0010, '0, 4'hf, OKAY, 0);
    add_entry("sram rd word 0x010", OP_RD, 32'h8000_0010, '0, 4'h0, OKAY, 0);
    add_entry("sram wr bytes 0x010", OP_WR, 32'h8000_0010, '0, 4'h5, OKAY, 0);
    add_entry("sram rd alias 0x410", OP_RD, 32'h8000_0410, '0, 4'h0, OKAY, 0);
    add_entry("clint rd mtime lo", OP_RD, CLINT_MTIME_LO, '0, 4'h0, OKAY, 0);
    add_entry("clint rd mtime hi", OP_RD, CLINT_MTIME_HI, '0, 4'h0, OKAY, 0);
    add_entry("clint rd mtime lo again", OP_RD, CLINT_MTIME_LO, '0, 4'h0, OKAY, 0);
    add_entry("uart wr byte a", OP_WR, UART_TX_ADDR, 32'h0000_0041, 4'h1, OKAY, 0);
    add_entry("uart wr no strobe", OP_WR, UART_TX_ADDR, 32'h0000_0042, 4'he, SLVERR, 0);
    add_entry("uart wr byte b", OP_WR, UART_TX_ADDR, 32'hdead_be43, 4'hf, OKAY, 0);
    add_entry("uart wr byte c", OP_WR, UART_TX_ADDR, 32'h0000_0044, 4'h1, OKAY, 0);
    add_entry("rd unmapped", OP_RD, 32'h1000_0000, '0, 4'h0, DECERR, 0);
    add_entry("rd uart tx", OP_RD, UART_TX_ADDR, '0, 4'h0, DECERR, 0);
    add_entry("wr clint mtime", OP_WR, CLINT_MTIME_LO, 32'h1, 4'hf, DECERR, 0);
    add_entry("sram rd after errors", OP_RD, 32'h8000_0010, '0, 4'h0, OKAY, 0);
    add_entry("sram wr b stalled", OP_WR, 32'h8000_0200, '0, 4'hf, OKAY, 5);
    add_entry("sram rd r stalled", OP_RD, 32'h8000_0200, '0, 4'h0, OKAY, 6);
    repeat (3) @(posedge clk);
    #2 rstn = 1'b0;
    for (int i = 0; i < n_tbl; i++) begin
      e = tbl[i];
      if (e.op == OP_WR) begin
        data = e.data;
        if (e.addr[31:27] == 5'b10000) begin
          data_st = xorshift(data_st);
          data    = data_st;
          for (int b = 0; b < 4; b++) begin
            if (e.strb[b]) shadow[e.addr[9:2]][8*b +: 8] = data[8*b +: 8];
          end
        end else if (e.addr == UART_TX_ADDR && e.strb[0]) begin
          exp_q.push_back(data[7:0]);
        end
        do_write(e, data, resp);
      end else begin
        do_read(e, data, resp);
        exp = (e.addr[31:27] == 5'b10000) ? shadow[e.addr[9:2]] : e.data;
        if (e.addr == CLINT_MTIME_LO) begin
          check_eq({e.name, " advanced"}, 64'd1, 64'(data > last_lo));
          last_lo = data;
        end else begin
          check_eq(e.name, 64'(exp), 64'(data));
        end
      end
      check_eq({e.name, " resp"}, 64'(e.resp), 64'(resp));
    end
    while (rx_q.size() < exp_q.size()) @(posedge clk);
    repeat (8) @(posedge clk); // no stray byte may follow.
    check_eq("uart byte count", 64'(exp_q.size()), 64'(rx_q.size()));
    foreach (exp_q[k]) check_eq($sformatf("uart byte %0d", k), 64'(exp_q[k]), 64'(rx_q[k]));
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== soc_bus_top.f ====
soc_bus_pkg.sv
axi_xbar.sv
axi_sram.sv
axi_clint.sv
axi_uart_tx.sv
soc_bus_top.sv
tb_soc_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
RTL_TOP   ?= soc_bus_top
FILELIST  ?= soc_bus_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
